// File: src.f
+incdir+rtl
rtl/tcb_pkg.sv
rtl/tcb_decode.sv
rtl/tcb_exec.sv
rtl/tcb_result.sv
rtl/tcb_periph.sv
dv/tcb_periph_chk.sv
dv/tcb_periph_tb.sv

// File: Makefile
# Verilator flow for the TCB register peripheral
# any variable below can be set on the command line

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tcb_periph_tb
RTL_TOP   ?= tcb_periph
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?=

.PHONY: all lint build sim clean

all: sim

# design only, full warning set
lint:
	$(VERILATOR) --lint-only -Wall --timing $(VFLAGS) \
	  -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing --assert -j $(JOBS) $(VFLAGS) \
	  -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# verdict comes from the log
sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tcb_periph_tb.sv
//////////////////////////////////////////////////
// testbench for the register peripheral
// drives a table of requests on falling edges and
// hands expected responses to the checker
//////////////////////////////////////////////////

`include "tcb_defines.svh"

module tcb_periph_tb
  import tcb_pkg::*;
();

  // characters per entry name
  localparam int nl = 16;
  // cycles allowed for outstanding responses
  localparam int drain_max = 20;
  // cycles watched for stray responses
  localparam int quiet = 8;

  // one table row, gap is idle cycles after it
  typedef struct packed {
    logic [8*nl-1:0]    name;
    logic               wen;
    logic [`TCB_AW-1:0] adr;
    logic [`TCB_BW-1:0] ben;
    logic [`TCB_DW-1:0] wdt;
    logic [`TCB_DW-1:0] exp_rdt;
    logic               exp_err;
    int                 gap;
  } entry_t;

  logic            bus;
  logic            rst_n;
  tcb_req_t        req;
  tcb_rsp_t        rsp;
  tcb_rsp_t        exp_rsp;
  logic [8*nl-1:0] exp_name;
  int              chk_err;
  int              exp_cnt;
  int              rsp_cnt;

  entry_t tbl [$];
  int     tb_err;

  tcb_periph dut_i (
    .bus   (bus),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
  );

  tcb_periph_chk #(.nl(nl)) chk_i (
    .bus      (bus),
    .rst_n    (rst_n),
    .rsp      (rsp),
    .exp_rsp  (exp_rsp),
    .exp_name (exp_name),
    .err_cnt  (chk_err),
    .exp_cnt  (exp_cnt),
    .rsp_cnt  (rsp_cnt)
  );

  // period 4
  initial begin
    bus = 1'b0;
    forever begin
      #2 bus = ~bus;
    end
  end

  //////////////////////////////////////////////////
  // table and drivers
  //////////////////////////////////////////////////

  task automatic add_entry(
    input logic [8*nl-1:0]    name,
    input logic               wen,
    input logic [`TCB_AW-1:0] adr,
    input logic [`TCB_BW-1:0] ben,
    input logic [`TCB_DW-1:0] wdt,
    input logic [`TCB_DW-1:0] exp_rdt,
    input logic               exp_err,
    input int                 gap
  );
    entry_t e;
    e = '{name: name, wen: wen, adr: adr, ben: ben, wdt: wdt,
          exp_rdt: exp_rdt, exp_err: exp_err, gap: gap};
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // scratch words and id word after reset
    add_entry("rd_s0",       1'b0, 32'h00, 4'hf, 32'h0, 32'h0, 1'b0, 0);
    add_entry("rd_s7",       1'b0, 32'h1c, 4'hf, 32'h0, 32'h0, 1'b0, 0);
    add_entry("rd_id",       1'b0, 32'h20, 4'hf, 32'h0, `TCB_ID_VAL, 1'b0, 1);
    // full word write then read back
    add_entry("wr_s1",       1'b1, 32'h04, 4'hf, 32'h1122_3344, 32'h0, 1'b0, 2);
    add_entry("rd_s1",       1'b0, 32'h04, 4'hf, 32'h0, 32'h1122_3344, 1'b0, 1);
    // lanes 0 and 2 of 11223344 replaced from aabbccdd
    add_entry("wr_s1_b02",   1'b1, 32'h04, 4'h5, 32'haabb_ccdd, 32'h0, 1'b0, 0);
    add_entry("rd_s1_b02",   1'b0, 32'h04, 4'hf, 32'h0, 32'h11bb_33dd, 1'b0, 0);
    // lane 3 only on a zero word
    add_entry("wr_s2_b3",    1'b1, 32'h08, 4'h8, 32'hdead_beef, 32'h0, 1'b0, 0);
    add_entry("rd_s2_b3",    1'b0, 32'h08, 4'hf, 32'h0, 32'hde00_0000, 1'b0, 2);
    // faults, each aimed at a word that holds data
    add_entry("wr_misalign", 1'b1, 32'h0a, 4'hf, 32'hffff_ffff, 32'h0, 1'b1, 0);
    add_entry("rd_misalign", 1'b0, 32'h05, 4'hf, 32'h0, 32'h0, 1'b1, 0);
    add_entry("wr_range",    1'b1, 32'h24, 4'hf, 32'hffff_ffff, 32'h0, 1'b1, 0);
    add_entry("rd_range",    1'b0, 32'h40, 4'hf, 32'h0, 32'h0, 1'b1, 0);
    add_entry("wr_id",       1'b1, 32'h20, 4'hf, 32'h5555_aaaa, 32'h0, 1'b1, 1);
    // nothing moved
    add_entry("rd_s2_after", 1'b0, 32'h08, 4'hf, 32'h0, 32'hde00_0000, 1'b0, 0);
    add_entry("rd_s1_after", 1'b0, 32'h04, 4'hf, 32'h0, 32'h11bb_33dd, 1'b0, 0);
    add_entry("rd_s0_after", 1'b0, 32'h00, 4'hf, 32'h0, 32'h0, 1'b0, 0);
    add_entry("rd_id_after", 1'b0, 32'h20, 4'hf, 32'h0, `TCB_ID_VAL, 1'b0, 3);
    // back to back, read right behind each write
    add_entry("wr_s3",       1'b1, 32'h0c, 4'hf, 32'h0123_4567, 32'h0, 1'b0, 0);
    add_entry("rd_s3",       1'b0, 32'h0c, 4'hf, 32'h0, 32'h0123_4567, 1'b0, 0);
    add_entry("wr_s3_b1",    1'b1, 32'h0c, 4'h2, 32'hffff_a5ff, 32'h0, 1'b0, 0);
    add_entry("rd_s3_b1",    1'b0, 32'h0c, 4'hf, 32'h0, 32'h0123_a567, 1'b0, 0);
    add_entry("wr_s7",       1'b1, 32'h1c, 4'hf, 32'hcafe_f00d, 32'h0, 1'b0, 0);
    add_entry("rd_s7_new",   1'b0, 32'h1c, 4'hf, 32'h0, 32'hcafe_f00d, 1'b0, 0);
    add_entry("rd_s3_last",  1'b0, 32'h0c, 4'hf, 32'h0, 32'h0123_a567, 1'b0, 0);
  endtask

  task automatic send_entry(input entry_t e);
    req      = '{valid: 1'b1, wen: e.wen, adr: e.adr, ben: e.ben, wdt: e.wdt};
    exp_rsp  = '{valid: 1'b1, rdt: e.exp_rdt, error: e.exp_err};
    exp_name = e.name;
  endtask

  task automatic drive_idle();
    req      = '0;
    exp_rsp  = '0;
    exp_name = '0;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int waited;
    drive_idle();
    rst_n  = 1'b0;
    tb_err = 0;
    build_table();
    for (int i = 0; i < 5; i++) begin
      @(posedge bus);
    end
    @(negedge bus);
    rst_n = 1'b1;
    // one entry per falling edge
    for (int i = 0; i < tbl.size(); i++) begin
      @(negedge bus);
      send_entry(tbl[i]);
      for (int g = 0; g < tbl[i].gap; g++) begin
        @(negedge bus);
        drive_idle();
      end
    end
    @(negedge bus);
    drive_idle();
    // drain with a bound
    waited = 0;
    @(posedge bus);
    while (rsp_cnt < exp_cnt && waited < drain_max) begin
      @(posedge bus);
      waited++;
    end
    if (rsp_cnt < exp_cnt) begin
      $display("timeout: %0d responses still outstanding after %0d cycles",
               exp_cnt - rsp_cnt, drain_max);
      tb_err++;
    end
    // bus must stay quiet
    for (int i = 0; i < quiet; i++) begin
      @(posedge bus);
    end
    if (rsp_cnt != tbl.size()) begin
      $display("error: saw %0d responses for %0d requests", rsp_cnt, tbl.size());
      tb_err++;
    end
    $display("errors: checker %0d, testbench %0d, responses %0d of %0d",
             chk_err, tb_err, rsp_cnt, tbl.size());
    if (chk_err == 0 && tb_err == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: dv/tcb_periph_chk.sv
//////////////////////////////////////////////////
// response checker for the register peripheral
// queues expected entries from the testbench and
// compares each bus response in order
//////////////////////////////////////////////////

`include "tcb_defines.svh"

module tcb_periph_chk
  import tcb_pkg::*;
#(
  // characters per entry name
  parameter int nl = 16
)(
  input  logic            bus,
  input  logic            rst_n,
  // DUT response
  input  tcb_rsp_t        rsp,
  // expected response and its entry name
  input  tcb_rsp_t        exp_rsp,
  input  logic [8*nl-1:0] exp_name,
  output int              err_cnt,
  output int              exp_cnt,
  output int              rsp_cnt
);

  // edges from request to response, the accepting edge counted
  localparam int lat = 2 + `TCB_DLY;

  typedef struct packed {
    logic [8*nl-1:0] name;
    tcb_rsp_t        rsp;
    int              stamp;
  } pend_t;

  pend_t q [$];
  // rising edge count
  int    cyc;
  // out of reset at the last rising edge
  bit    live;

  // packed name to string, leading nul bytes dropped
  function automatic string name_of(input logic [8*nl-1:0] v);
    string s;
    s = "";
    for (int i = nl - 1; i >= 0; i--) begin
      if (v[i*8 +: 8] != 8'h00) begin
        s = $sformatf("%s%c", s, v[i*8 +: 8]);
      end
    end
    return s;
  endfunction

  //////////////////////////////////////////////////
  // rising edge takes requests, falling edge checks
  //////////////////////////////////////////////////

  always @(posedge bus or negedge bus) begin
    pend_t e;
    string nm;
    int    took;
    if (bus) begin
      cyc  = cyc + 1;
      live = rst_n;
      // stamp with the accepting edge
      if (live && exp_rsp.valid) begin
        e = '{name: exp_name, rsp: exp_rsp, stamp: cyc};
        q.push_back(e);
        exp_cnt = exp_cnt + 1;
      end
    end else if (live) begin
      if ($isunknown(rsp.valid)) begin
        $display("error: rsp.valid is unknown at edge %0d", cyc);
        err_cnt = err_cnt + 1;
      end else if (rsp.valid) begin
        rsp_cnt = rsp_cnt + 1;
        if (q.size() == 0) begin
          // idle gaps and the tail must stay silent
          $display("error: response with no request outstanding, rdt %h", rsp.rdt);
          err_cnt = err_cnt + 1;
        end else begin
          e    = q.pop_front();
          nm   = name_of(e.name);
          took = cyc - e.stamp + 1;
          if (rsp.rdt !== e.rsp.rdt || rsp.error !== e.rsp.error) begin
            $display("mismatch %s: expected rdt %h error %b, actual rdt %h error %b",
                     nm, e.rsp.rdt, e.rsp.error, rsp.rdt, rsp.error);
            err_cnt = err_cnt + 1;
          end
          if (took != lat) begin
            $display("mismatch %s latency: expected %0d edges, actual %0d edges",
                     nm, lat, took);
            err_cnt = err_cnt + 1;
          end
        end
      end
    end
  end

endmodule

// File: rtl/tcb_periph.sv
//////////////////////////////////////////////////
// register peripheral top
// decode, execute and result stages in a row
// response comes 2 + delay edges after a request
//////////////////////////////////////////////////

module tcb_periph
  import tcb_pkg::*;
(
  // clock and reset
  input  logic     bus,
  input  logic     rst_n,
  // bus request and response
  input  tcb_req_t req,
  output tcb_rsp_t rsp
);

  //////////////////////////////////////////////////
  // stage links
  //////////////////////////////////////////////////

  // decoded operation
  tcb_dec_t dec;
  // response before the delay pipeline
  tcb_rsp_t raw;

  //////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////

  // classify one request per cycle
  tcb_decode decode_i (
    .bus   (bus),
    .rst_n (rst_n),
    .req   (req),
    .dec   (dec)
  );

  // scratch bank access
  tcb_exec exec_i (
    .bus   (bus),
    .rst_n (rst_n),
    .dec   (dec),
    .raw   (raw)
  );

  // response delay
  tcb_result result_i (
    .bus   (bus),
    .rst_n (rst_n),
    .raw   (raw),
    .rsp   (rsp)
  );

endmodule

// File: rtl/tcb_result.sv
//////////////////////////////////////////////////
// result stage
// delays the raw response by dly cycles and
// drives it onto the bus
//////////////////////////////////////////////////

`include "tcb_defines.svh"

module tcb_result
  import tcb_pkg::*;
#(
  // response delay in cycles
  parameter int unsigned dly = `TCB_DLY
)(
  input  logic     bus,
  input  logic     rst_n,
  input  tcb_rsp_t raw,
  output tcb_rsp_t rsp
);

  // at least one stage is needed
  if (dly < 1) begin : g_dly_check
    $error("tcb_result needs dly of 1 or more");
  end

  //////////////////////////////////////////////////
  // shift pipeline
  //////////////////////////////////////////////////

  logic               vld_q [dly];
  logic [`TCB_DW-1:0] rdt_q [dly];
  logic               err_q [dly];

  // valid bits
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < dly; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= raw.valid;
      for (int i = 1; i < dly; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // data and error follow along
  always_ff @(posedge bus) begin
    rdt_q[0] <= raw.rdt;
    err_q[0] <= raw.error;
    for (int i = 1; i < dly; i++) begin
      rdt_q[i] <= rdt_q[i-1];
      err_q[i] <= err_q[i-1];
    end
  end

  // last stage drives the bus
  assign rsp = '{valid: vld_q[dly-1], rdt: rdt_q[dly-1], error: err_q[dly-1]};

  a_rsp_error_known: assert property (
    @(posedge bus) disable iff (!rst_n) rsp.valid |-> !$isunknown(rsp.error)
  ) else $error("rsp.error is unknown on a valid response");

endmodule

// File: rtl/tcb_exec.sv
//////////////////////////////////////////////////
// execute stage
// holds the scratch bank, applies decoded
// operations in order and forms the raw response
//////////////////////////////////////////////////

`include "tcb_defines.svh"

module tcb_exec
  import tcb_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  tcb_dec_t dec,
  output tcb_rsp_t raw
);

  // bits per byte lane
  localparam int unsigned sw = `TCB_DW / `TCB_BW;

  //////////////////////////////////////////////////
  // scratch bank
  //////////////////////////////////////////////////

  logic [`TCB_DW-1:0] mem [`TCB_NREG];

  // words must read zero after reset
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `TCB_NREG; i++) begin
        mem[i] <= '0;
      end
    end else if (dec.op == op_write) begin
      // only enabled lanes change
      for (int b = 0; b < `TCB_BW; b++) begin
        if (dec.ben[b]) begin
          mem[dec.idx][b*sw +: sw] <= dec.wdt[b*sw +: sw];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // response forming
  //////////////////////////////////////////////////

  logic [`TCB_DW-1:0] rdt_nxt;
  logic               err_nxt;

  always_comb begin
    rdt_nxt = '0;
    err_nxt = 1'b0;
    case (dec.op)
      op_read: begin
        // id word or a scratch word
        rdt_nxt = dec.id ? `TCB_ID_VAL : mem[dec.idx];
      end
      op_fault: begin
        // zero data, bank untouched
        err_nxt = 1'b1;
      end
      default: begin
        // write answers zero without error
        rdt_nxt = '0;
      end
    endcase
  end

  logic               vld_q;
  logic [`TCB_DW-1:0] rdt_q;
  logic               err_q;

  // one response for every non idle opcode
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= dec.op != op_idle;
    end
  end

  always_ff @(posedge bus) begin
    rdt_q <= rdt_nxt;
    err_q <= err_nxt;
  end

  assign raw = '{valid: vld_q, rdt: rdt_q, error: err_q};

  // decode turns id writes into faults
  a_write_scratch: assert property (
    @(posedge bus) disable iff (!rst_n) (dec.op == op_write) |-> !dec.id
  ) else $error("write opcode selects the id word");

endmodule

// File: rtl/tcb_decode.sv
//////////////////////////////////////////////////
// request decode stage
// registers each accepted request and classifies
// it into an opcode, register index and fault
//////////////////////////////////////////////////

`include "tcb_defines.svh"

module tcb_decode
  import tcb_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  tcb_req_t req,
  output tcb_dec_t dec
);

  // word address width
  localparam int unsigned ww = `TCB_AW - tcb_ab;
  // id word follows the last scratch word
  localparam logic [ww-1:0] id_word = ww'(`TCB_NREG);

  //////////////////////////////////////////////////
  // classification
  //////////////////////////////////////////////////

  logic [ww-1:0] word;
  logic          misaligned;
  logic          out_of_range;
  logic          id_hit;
  tcb_op_e       op_nxt;

  assign word         = req.adr[`TCB_AW-1:tcb_ab];
  assign misaligned   = |req.adr[tcb_ab-1:0];
  assign out_of_range = word > id_word;
  assign id_hit       = word == id_word;

  always_comb begin
    if (!req.valid) begin
      op_nxt = op_idle;
    end else if (misaligned || out_of_range) begin
      op_nxt = op_fault;
    end else if (req.wen && id_hit) begin
      // id word is read only
      op_nxt = op_fault;
    end else begin
      op_nxt = req.wen ? op_write : op_read;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  tcb_op_e              op_q;
  logic                 id_q;
  logic [tcb_iw-1:0]    idx_q;
  logic [`TCB_BW-1:0]   ben_q;
  logic [`TCB_DW-1:0]   wdt_q;

  // opcode is the only control state here
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      op_q <= op_idle;
    end else begin
      op_q <= op_nxt;
    end
  end

  // payload only loads on a transfer
  always_ff @(posedge bus) begin
    if (req.valid) begin
      id_q  <= id_hit;
      idx_q <= word[tcb_iw-1:0];
      ben_q <= req.ben;
      wdt_q <= req.wdt;
    end
  end

  assign dec = '{op: op_q, id: id_q, idx: idx_q, ben: ben_q, wdt: wdt_q};

  // manager must never leave valid floating
  a_req_valid_known: assert property (
    @(posedge bus) disable iff (!rst_n) !$isunknown(req.valid)
  ) else $error("req.valid is unknown");

endmodule

// File: rtl/tcb_pkg.sv
//////////////////////////////////////////////////
// types of the register peripheral
// request, decoded operation and response structs
// import with a wildcard in the module header
//////////////////////////////////////////////////

package tcb_pkg;

  `include "tcb_defines.svh"

  // register index width
  localparam int unsigned tcb_iw = $clog2(`TCB_NREG);
  // byte offset bits inside a word address
  localparam int unsigned tcb_ab = $clog2(`TCB_BW);

  //////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////

  // request from the manager
  typedef struct packed {
    logic               valid;
    logic               wen;
    logic [`TCB_AW-1:0] adr;
    logic [`TCB_BW-1:0] ben;
    logic [`TCB_DW-1:0] wdt;
  } tcb_req_t;

  // response back to the manager
  typedef struct packed {
    logic               valid;
    logic [`TCB_DW-1:0] rdt;
    logic               error;
  } tcb_rsp_t;

  //////////////////////////////////////////////////
  // between decode and execute
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    op_idle,
    op_read,
    op_write,
    op_fault
  } tcb_op_e;

  // id set selects the id word, idx is then ignored
  typedef struct packed {
    tcb_op_e            op;
    logic               id;
    logic [tcb_iw-1:0]  idx;
    logic [`TCB_BW-1:0] ben;
    logic [`TCB_DW-1:0] wdt;
  } tcb_dec_t;

endpackage

// File: rtl/tcb_defines.svh
//////////////////////////////////////////////////
// bus widths, register map and response delay of
// the register peripheral, shared by RTL and testbench
// include wherever a macro below is used
//////////////////////////////////////////////////

`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

// address width in bits
`define TCB_AW 32

// data width in bits
`define TCB_DW 32

// one enable per data byte
`define TCB_BW 4

// scratch words, the id word sits right after them
`define TCB_NREG 8

// constant returned by a read of the id word
`define TCB_ID_VAL 32'h7cb0_01a5

// response pipeline depth
// valid range is 1 to 3
`define TCB_DLY 1

`endif
